// File: hdl/conv_pkg.sv
package conv_pkg;

	// Word widths on the datapath
	localparam int DATA_W = 16;		// Activation and weight word
	localparam int ACC_W = 32;		// Product, accumulator, result
	localparam int TAP_W = 4;		// Tap count and index

	// Default engine sizes
	localparam int DEFAULT_LANES = 16;	// Channel lanes per atom, one DMA burst
	localparam int DEFAULT_MAX_TAPS = 9;	// Weight bank depth, 3x3 kernel

	// One signed 16-bit activation or weight
	typedef logic signed [DATA_W-1:0] data_t;

	// Signed 32-bit product, lane sum or final result
	// All arithmetic on it wraps at 32 bits
	typedef logic signed [ACC_W-1:0] acc_t;

	// Kernel tap count or tap position, 1 to 15 usable
	typedef logic [TAP_W-1:0] tap_cnt_t;

endpackage

// File: hdl/atom_deserializer.sv
module atom_deserializer #(
	parameter int LANES = conv_pkg::DEFAULT_LANES
) (
	input  logic                            clk,
	input  logic                            rst,
	input  conv_pkg::data_t                 i_word,		// Serial word from DMA
	input  logic                            i_word_stb,
	output conv_pkg::data_t [LANES-1:0]     o_atom,		// Lane k holds word k
	output logic                            o_atom_stb	// One cycle per full atom
);

	import conv_pkg::*;

	localparam int CNT_W = (LANES > 1) ? $clog2(LANES) : 1;

	data_t [LANES-1:0] shift_buf;	// Partial atom, newest word at the top
	logic [CNT_W-1:0] lane_cnt;	// Words taken into the current atom
	logic last_word;

	// The LANES-th word closes the atom
	assign last_word = (lane_cnt == CNT_W'(LANES - 1));

	// Shift new words in from the top so word 0 ends in lane 0
	always_ff @(posedge clk) begin
		if (i_word_stb) begin
			shift_buf <= {i_word, shift_buf[LANES-1:1]};
		end
	end

	// Completed atom, copied out when the counter wraps
	always_ff @(posedge clk) begin
		if (i_word_stb && last_word) begin
			o_atom <= {i_word, shift_buf[LANES-1:1]};	// Include the closing word
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_cnt   <= '0;
			o_atom_stb <= 1'b0;
		end else begin
			o_atom_stb <= i_word_stb && last_word;	// Single-cycle pulse
			if (i_word_stb) begin
				if (last_word) begin
					lane_cnt <= '0;		// Wrap for the next atom
				end else begin
					lane_cnt <= lane_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/weight_bank.sv
module weight_bank #(
	parameter int LANES = conv_pkg::DEFAULT_LANES,
	parameter int MAX_TAPS = conv_pkg::DEFAULT_MAX_TAPS
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_start,	// New run, reload weights
	input  conv_pkg::tap_cnt_t              i_taps,		// Taps per window, sampled at start
	input  conv_pkg::data_t [LANES-1:0]     i_w_atom,
	input  logic                            i_w_atom_stb,
	input  conv_pkg::data_t [LANES-1:0]     i_d_atom,
	input  logic                            i_d_atom_stb,
	output conv_pkg::data_t [LANES-1:0]     o_pair_data,
	output conv_pkg::data_t [LANES-1:0]     o_pair_weight,
	output logic                            o_pair_last,	// Last tap of the window
	output logic                            o_pair_stb
);

	import conv_pkg::*;

	typedef enum logic {
		ST_LOAD,	// Collecting weight atoms
		ST_RUN		// Pairing data atoms with weights
	} bank_state_t;

	bank_state_t state;
	data_t [LANES-1:0] w_mem [MAX_TAPS];	// One weight atom per tap
	tap_cnt_t wr_ptr;			// Next weight atom slot
	tap_cnt_t taps_q;			// Latched window length
	tap_cnt_t tap_pos;			// Tap of the next data atom
	logic last_tap;
	logic w_last;
	logic pair_fire;

	assign last_tap  = (tap_pos == tap_cnt_t'(taps_q - 1'b1));
	assign w_last    = (wr_ptr == tap_cnt_t'(taps_q - 1'b1));
	assign pair_fire = i_d_atom_stb && (state == ST_RUN);	// Data in LOAD is dropped

	// Weight storage, writes past the bank depth are dropped
	always_ff @(posedge clk) begin
		if (i_w_atom_stb && !i_start && state == ST_LOAD && wr_ptr < tap_cnt_t'(MAX_TAPS)) begin
			w_mem[wr_ptr] <= i_w_atom;
		end
	end

	// Pair payload, data with the weight of its tap
	always_ff @(posedge clk) begin
		if (pair_fire) begin
			o_pair_data   <= i_d_atom;
			o_pair_weight <= w_mem[tap_pos];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= ST_LOAD;
			wr_ptr      <= '0;
			taps_q      <= tap_cnt_t'(1);
			tap_pos     <= '0;
			o_pair_last <= 1'b0;
			o_pair_stb  <= 1'b0;
		end else begin
			o_pair_stb <= pair_fire && !i_start;
			if (i_start) begin
				state   <= ST_LOAD;
				wr_ptr  <= '0;
				tap_pos <= '0;
				// Clamp to the bank depth
				if (i_taps > tap_cnt_t'(MAX_TAPS)) taps_q <= tap_cnt_t'(MAX_TAPS);
				else taps_q <= i_taps;
			end else begin
				case (state)
					ST_LOAD: begin
						if (i_w_atom_stb) begin
							wr_ptr <= wr_ptr + 1'b1;
							if (w_last) state <= ST_RUN;	// Bank full for this kernel
						end
					end
					ST_RUN: begin
						if (i_d_atom_stb) begin
							o_pair_last <= last_tap;
							tap_pos     <= last_tap ? tap_cnt_t'(0) : tap_pos + 1'b1;
						end
					end
					default: state <= ST_LOAD;
				endcase
			end
		end
	end

endmodule

// File: hdl/lane_mac_array.sv
module lane_mac_array #(
	parameter int LANES = conv_pkg::DEFAULT_LANES
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_start,	// Clears the running sums
	input  conv_pkg::data_t [LANES-1:0]     i_pair_data,
	input  conv_pkg::data_t [LANES-1:0]     i_pair_weight,
	input  logic                            i_pair_last,
	input  logic                            i_pair_stb,
	output conv_pkg::acc_t [LANES-1:0]      o_lane_acc,	// Window sum per lane
	output logic                            o_lane_acc_stb
);

	import conv_pkg::*;

	acc_t [LANES-1:0] prod_q;	// Registered lane products
	acc_t [LANES-1:0] acc_q;	// Running sums over the window taps
	logic prod_stb;			// Strobe aligned with prod_q
	logic prod_last;		// Last-tap flag aligned with prod_q
	logic hand_off;

	// Window done once the last product is added
	assign hand_off = prod_stb && prod_last;

	// Stage 1 control, strobe and last flag follow the products
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_stb  <= 1'b0;
			prod_last <= 1'b0;
		end else begin
			prod_stb <= i_pair_stb;
			if (i_pair_stb) prod_last <= i_pair_last;
		end
	end

	// Stage 2 control, one strobe per finished window
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_lane_acc_stb <= 1'b0;
		end else begin
			o_lane_acc_stb <= hand_off;
		end
	end

	genvar l;
	generate
		for (l = 0; l < LANES; l = l + 1) begin : g_lane
			acc_t sum_next;

			// Product plus the running sum of this lane
			assign sum_next = acc_q[l] + prod_q[l];

			// Stage 1, signed 16x16 into 32 bits
			always_ff @(posedge clk) begin
				if (i_pair_stb) begin
					prod_q[l] <= i_pair_data[l] * i_pair_weight[l];
				end
			end

			// Stage 2, accumulate and hand off
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					acc_q[l]      <= '0;
					o_lane_acc[l] <= '0;
				end else if (i_start) begin
					acc_q[l] <= '0;		// Fresh run
				end else if (prod_stb) begin
					if (prod_last) begin
						o_lane_acc[l] <= sum_next;	// Completed window
						acc_q[l]      <= '0;		// Ready for the next window at once
					end else begin
						acc_q[l] <= sum_next;
					end
				end
			end
		end
	endgenerate

endmodule

// File: hdl/lane_reduce.sv
module lane_reduce #(
	parameter int LANES = conv_pkg::DEFAULT_LANES	// Power of two
) (
	input  logic                            clk,
	input  logic                            rst,
	input  conv_pkg::acc_t [LANES-1:0]      i_lane_acc,
	input  logic                            i_lane_acc_stb,
	output conv_pkg::acc_t                  o_result,	// Sum of all lanes
	output logic                            o_result_stb
);

	import conv_pkg::*;

	localparam int LEVELS = $clog2(LANES);	// One register per tree level

	// Heap-indexed internal nodes, node 1 is the root
	// Children of node n are 2n and 2n+1, indices from LANES up are the lanes
	acc_t tree_q [1:LANES-1];
	logic [LEVELS-1:0] stb_pipe;	// Strobe delay matching the tree depth

	genvar n;
	generate
		for (n = 1; n < LANES; n = n + 1) begin : g_node
			acc_t left;
			acc_t right;

			// Bottom level reads the lane sums directly
			if (2 * n >= LANES) begin : g_leaf
				assign left  = i_lane_acc[2 * n - LANES];
				assign right = i_lane_acc[2 * n + 1 - LANES];
			end else begin : g_inner
				assign left  = tree_q[2 * n];
				assign right = tree_q[2 * n + 1];
			end

			// Free running, values only change on a window hand-off
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					tree_q[n] <= '0;
				end else begin
					tree_q[n] <= left + right;	// Wraps at 32 bits
				end
			end
		end
	endgenerate

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stb_pipe <= '0;
		end else begin
			stb_pipe <= (stb_pipe << 1) | LEVELS'(i_lane_acc_stb);
		end
	end

	assign o_result     = tree_q[1];
	assign o_result_stb = stb_pipe[LEVELS-1];	// Leaves the root with its sum

endmodule

// File: hdl/conv_engine_top.sv
module conv_engine_top #(
	parameter int LANES = conv_pkg::DEFAULT_LANES,
	parameter int MAX_TAPS = conv_pkg::DEFAULT_MAX_TAPS
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_start,	// Begin a run
	input  conv_pkg::tap_cnt_t      i_taps,		// Atoms per window
	input  conv_pkg::data_t         i_weight_word,
	input  logic                    i_weight_stb,
	input  conv_pkg::data_t         i_data_word,
	input  logic                    i_data_stb,
	output conv_pkg::acc_t          o_result,	// One value per window
	output logic                    o_result_stb
);

	import conv_pkg::*;

	data_t [LANES-1:0] w_atom;
	logic w_atom_stb;
	data_t [LANES-1:0] d_atom;
	logic d_atom_stb;
	data_t [LANES-1:0] pair_data;
	data_t [LANES-1:0] pair_weight;
	logic pair_last;
	logic pair_stb;
	acc_t [LANES-1:0] lane_acc;
	logic lane_acc_stb;

	// Weight stream into atoms
	atom_deserializer #(.LANES(LANES)) u_w_deser (
		.clk        (clk),
		.rst        (rst),
		.i_word     (i_weight_word),
		.i_word_stb (i_weight_stb),
		.o_atom     (w_atom),
		.o_atom_stb (w_atom_stb)
	);

	// Activation stream into atoms
	atom_deserializer #(.LANES(LANES)) u_d_deser (
		.clk        (clk),
		.rst        (rst),
		.i_word     (i_data_word),
		.i_word_stb (i_data_stb),
		.o_atom     (d_atom),
		.o_atom_stb (d_atom_stb)
	);

	weight_bank #(.LANES(LANES), .MAX_TAPS(MAX_TAPS)) u_bank (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_taps        (i_taps),
		.i_w_atom      (w_atom),
		.i_w_atom_stb  (w_atom_stb),
		.i_d_atom      (d_atom),
		.i_d_atom_stb  (d_atom_stb),
		.o_pair_data   (pair_data),
		.o_pair_weight (pair_weight),
		.o_pair_last   (pair_last),
		.o_pair_stb    (pair_stb)
	);

	lane_mac_array #(.LANES(LANES)) u_mac (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_pair_data    (pair_data),
		.i_pair_weight  (pair_weight),
		.i_pair_last    (pair_last),
		.i_pair_stb     (pair_stb),
		.o_lane_acc     (lane_acc),
		.o_lane_acc_stb (lane_acc_stb)
	);

	// Channel partial sums into one value
	lane_reduce #(.LANES(LANES)) u_reduce (
		.clk            (clk),
		.rst            (rst),
		.i_lane_acc     (lane_acc),
		.i_lane_acc_stb (lane_acc_stb),
		.o_result       (o_result),
		.o_result_stb   (o_result_stb)
	);

endmodule

// File: verification/tb_conv_tasks.svh
`ifndef TB_CONV_TASKS_SVH
`define TB_CONV_TASKS_SVH

// Value compare for results and other 32-bit quantities
task automatic check_result(input string name, input acc_t exp, input acc_t got);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail %s: expected 0x%08h, got 0x%08h at %0t", name, exp, got, $time);
	end
endtask

// Strobe count compare, missing or extra strobes
task automatic check_stb_count(input int exp, input int got);
	checks++;
	if (got != exp) begin
		errors++;
		$display("Result strobe count is wrong: expected %0d strobes, saw %0d at %0t",
			exp, got, $time);
	end
endtask

// Golden model, wrapped lane products summed over lanes and taps
function automatic acc_t ref_window(input int taps);
	acc_t sum;
	acc_t prod;
	int t;
	int l;
	sum = '0;
	for (t = 0; t < taps; t++) begin
		for (l = 0; l < LANES; l++) begin
			prod = acc_t'(win[t][l]) * acc_t'(wts[t][l]);	// Sign extend, wrap at 32
			sum  = sum + prod;
		end
	end
	return sum;
endfunction

// New run with a fresh tap count
task automatic start_run(input int taps);
	@(posedge clk);
	#2 i_start = 1'b1;
	i_taps = tap_cnt_t'(taps);
	@(posedge clk);
	#2 i_start = 1'b0;
endtask

// Weight words for n_atoms atoms, back to back
task automatic load_weights(input int n_atoms);
	int a;
	int l;
	for (a = 0; a < n_atoms; a++) begin
		for (l = 0; l < LANES; l++) begin
			@(posedge clk);
			#2 i_weight_word = wts[a][l];
			i_weight_stb = 1'b1;
		end
	end
	@(posedge clk);
	#2 i_weight_stb = 1'b0;
endtask

// One window of data atoms, optional random idle cycles between words
task automatic send_window(input int taps, input int max_gap, input bit keep_stb);
	int t;
	int l;
	int gap;
	for (t = 0; t < taps; t++) begin
		for (l = 0; l < LANES; l++) begin
			gap = (max_gap > 0) ? int'({$random(seed)} % (max_gap + 1)) : 0;
			repeat (gap) begin
				@(posedge clk);
				#2 i_data_stb = 1'b0;	// Idle cycle
			end
			@(posedge clk);
			#2 i_data_word = win[t][l];
			i_data_stb = 1'b1;
			last_data_cyc = cyc;	// Reference point for latency
		end
	end
	if (!keep_stb) begin
		@(posedge clk);
		#2 i_data_stb = 1'b0;
	end
endtask

// Waits for the next result and checks value and, if asked, latency
task automatic expect_result(input acc_t exp, input int exp_cyc);
	int i;
	acc_t got;
	int got_cyc;
	stb_expected++;
	for (i = 0; i < 40 && res_q.size() == 0; i++) @(posedge clk);
	if (res_q.size() == 0) begin
		errors++;
		$display("Expected a result strobe but none came by %0t", $time);
	end else begin
		got     = res_q.pop_front();
		got_cyc = res_cyc_q.pop_front();
		check_result("o_result", exp, got);
		if (exp_cyc >= 0 && got_cyc != exp_cyc) begin
			errors++;
			$display("Result strobe came %0d cycles after the last word instead of %0d",
				got_cyc - last_data_cyc, exp_cyc - last_data_cyc);
		end
	end
endtask

// Lets the pipeline drain, then checks no extra strobes showed up
task automatic settle_and_count;
	repeat (12) @(posedge clk);
	check_stb_count(stb_expected, stb_seen);
	stb_expected = stb_seen;	// Realign so one fault is reported once
	res_q.delete();
	res_cyc_q.delete();
endtask

`endif

// File: verification/tb_conv_engine.sv
module tb_conv_engine;

	timeunit 1ns;
	timeprecision 100ps;

	import conv_pkg::*;

	localparam int LANES = DEFAULT_LANES;
	localparam int LATENCY = 8;			// Last word to result strobe
	localparam int TOTAL_WORDS = 64 + 432 + 432 + 208 + 160;	// Sum over tests
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + 200;

	logic clk = 1'b0;
	logic rst;
	logic i_start;
	tap_cnt_t i_taps;
	data_t i_weight_word;
	logic i_weight_stb;
	data_t i_data_word;
	logic i_data_stb;
	acc_t o_result;
	logic o_result_stb;

	integer seed = 32'h1b9f_7e59;
	int cyc = 0;			// Clock edge counter
	int last_data_cyc = 0;
	int errors = 0;
	int checks = 0;
	int stb_seen = 0;
	int stb_expected = 0;
	acc_t res_q [$];		// Captured results in order
	int res_cyc_q [$];
	acc_t exp_q [$];
	data_t wts [16][16];		// Weight atoms, [tap][lane]
	data_t win [16][16];		// Data atoms of one window

	`include "tb_conv_tasks.svh"

	always #10 clk = ~clk;	// 20 ns period

	always @(posedge clk) cyc <= cyc + 1;

	// Result monitor, samples mid cycle
	always @(negedge clk) begin
		if (o_result_stb === 1'b1) begin
			res_q.push_back(o_result);
			res_cyc_q.push_back(cyc);
			stb_seen++;
		end
	end

	conv_engine_top #(.LANES(LANES), .MAX_TAPS(DEFAULT_MAX_TAPS)) uut (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_taps        (i_taps),
		.i_weight_word (i_weight_word),
		.i_weight_stb  (i_weight_stb),
		.i_data_word   (i_data_word),
		.i_data_stb    (i_data_stb),
		.o_result      (o_result),
		.o_result_stb  (o_result_stb)
	);

	// Random fill helpers
	task automatic fill_random_weights(input int n_atoms);
		int a;
		int l;
		for (a = 0; a < n_atoms; a++)
			for (l = 0; l < LANES; l++) wts[a][l] = data_t'($random(seed));
	endtask

	task automatic fill_random_window(input int taps);
		int t;
		int l;
		for (t = 0; t < taps; t++)
			for (l = 0; l < LANES; l++) win[t][l] = data_t'($random(seed));
	endtask

	// Outputs quiet during reset and shortly after
	task automatic test_reset_state;
		int i;
		rst = 1'b1;
		for (i = 0; i < 14; i++) begin
			@(posedge clk);
			#2 if (i == 3) rst = 1'b0;	// Four cycles of reset
			check_result("o_result", '0, o_result);
			if (o_result_stb !== 1'b0) begin
				errors++;
				$display("Result strobe was high right after reset at %0t", $time);
			end
		end
		check_stb_count(0, stb_seen);
	endtask

	// One tap, one result per atom, exact latency
	task automatic test_single_tap;
		int a;
		int l;
		start_run(1);
		for (l = 0; l < LANES; l++) wts[0][l] = data_t'(l * 37 - 200);
		load_weights(1);
		for (a = 0; a < 3; a++) begin
			for (l = 0; l < LANES; l++) win[0][l] = data_t'((a + 1) * (l - 7) * 11);
			send_window(1, 0, 1'b0);
			expect_result(ref_window(1), last_data_cyc + LATENCY);
		end
		settle_and_count();
	endtask

	// Full 3x3 kernel, random words with random gaps
	task automatic test_full_kernel;
		int w;
		start_run(9);
		fill_random_weights(9);
		load_weights(9);
		for (w = 0; w < 2; w++) begin
			fill_random_window(9);
			send_window(9, 3, 1'b0);
			expect_result(ref_window(9), -1);
		end
		settle_and_count();
	endtask

	// Three windows with no idle cycles, weights kept from before
	task automatic test_back_to_back;
		int w;
		for (w = 0; w < 3; w++) begin
			fill_random_window(9);
			exp_q.push_back(ref_window(9));
			send_window(9, 0, w < 2);
		end
		for (w = 0; w < 3; w++) expect_result(exp_q.pop_front(), -1);
		settle_and_count();
	endtask

	// New tap count, one surplus weight atom that must be ignored
	task automatic test_reload;
		int w;
		start_run(4);
		fill_random_weights(5);
		load_weights(5);
		for (w = 0; w < 2; w++) begin
			fill_random_window(4);
			send_window(4, 1, 1'b0);
			expect_result(ref_window(4), -1);
		end
		settle_and_count();
	endtask

	// Most negative words everywhere, sums wrap at 32 bits
	task automatic test_wrapping;
		int t;
		int l;
		start_run(5);
		for (t = 0; t < 5; t++) begin
			for (l = 0; l < LANES; l++) begin
				wts[t][l] = data_t'(16'h8000);
				win[t][l] = data_t'(16'h8000);
			end
		end
		load_weights(5);
		send_window(5, 0, 1'b0);
		expect_result(ref_window(5), -1);
		settle_and_count();
	endtask

	// Watchdog sized from the word count
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		i_start = 1'b0;
		i_taps = '0;
		i_weight_word = '0;
		i_weight_stb = 1'b0;
		i_data_word = '0;
		i_data_stb = 1'b0;
		test_reset_state();
		test_single_tap();
		test_full_kernel();
		test_back_to_back();
		test_reload();
		test_wrapping();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+verification
hdl/conv_pkg.sv
hdl/atom_deserializer.sv
hdl/weight_bank.sv
hdl/lane_mac_array.sv
hdl/lane_reduce.sv
hdl/conv_engine_top.sv
verification/tb_conv_engine.sv
